// ==== logic/core_bus_pkg.sv ====
package core_bus_pkg;

	// Data port commands
	// Three bits leave room for further commands
	typedef enum logic [2:0] {
		cmd_idle  = 3'd0,
		cmd_read  = 3'd1,
		cmd_write = 3'd2
	} mem_cmd_t;

	// Address and data width of both memory ports
	localparam int unsigned word_bits = 32;

endpackage

// ==== logic/core_isa_pkg.sv ====
package core_isa_pkg;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_jal    = 7'b1101111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b
	} alu_op_t;

	// Always is used by JAL
	typedef enum logic [2:0] {br_none, br_eq, br_ne, br_lt, br_ge, br_always} br_cond_t;

	// Writeback source in the memory stage
	typedef enum logic [1:0] {wb_none, wb_alu, wb_mem, wb_pc4} wb_sel_t;

	//********************
	// Stage packets
	//********************

	// Fetch to decode
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} decode_in_t;

	// Decode to execute
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] op_a;
		logic [31:0] op_b;
		logic [31:0] store_data;
		logic [31:0] br_imm;
		alu_op_t     alu_op;
		br_cond_t    br_cond;
		wb_sel_t     wb_sel;
		logic [4:0]  rd;
		logic        is_load;
		logic        is_store;
	} exec_in_t;

	// Execute to memory
	typedef struct packed {
		logic [31:0] alu_result;
		logic [31:0] pc4;
		logic [31:0] store_data;
		logic [4:0]  rd;
		wb_sel_t     wb_sel;
		logic        is_load;
		logic        is_store;
	} mem_in_t;

endpackage

// ==== logic/core_mem_if.sv ====
`timescale 1ns/1ps

// Instruction port
// One request in flight, answer comes back as a valid pulse
interface inst_port_if import core_bus_pkg::*; ();
	logic                 start;
	logic                 ready;
	logic [word_bits-1:0] addr;
	logic [word_bits-1:0] inst;
	logic                 valid;

	modport requester (output start, output addr, input ready, input inst, input valid);
	modport memory (input start, input addr, output ready, output inst, output valid);
endinterface

// Data port
// Command held until cmd_ready, read data later with rdata_valid
interface data_port_if import core_bus_pkg::*; ();
	mem_cmd_t             cmd;
	logic                 cmd_ready;
	logic [word_bits-1:0] addr;
	logic [word_bits-1:0] wdata;
	logic [word_bits-1:0] rdata;
	logic                 rdata_valid;

	modport requester (
		output cmd, output addr, output wdata,
		input cmd_ready, input rdata, input rdata_valid
	);
	modport memory (
		input cmd, input addr, input wdata,
		output cmd_ready, output rdata, output rdata_valid
	);
endinterface

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file import core_bus_pkg::*; #(
	parameter logic [word_bits-1:0] sp_init = 32'd1000
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [4:0]           rs1_addr,
	input  logic [4:0]           rs2_addr,
	output logic [word_bits-1:0] rs1_data,
	output logic [word_bits-1:0] rs2_data,
	input  logic                 wb_en,
	input  logic [4:0]           wb_addr,
	input  logic [word_bits-1:0] wb_data
);
	logic [word_bits-1:0] regs [32];

	// Stack pointer starts at sp_init, the rest at zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
			regs[2] <= sp_init;
		end else if (wb_en && wb_addr != 5'd0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Async reads, x0 hardwired
	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import core_isa_pkg::*, core_bus_pkg::*; #(
	parameter logic [word_bits-1:0] reset_pc = '0
) (
	input  logic                 clk,
	input  logic                 reset,
	inst_port_if.requester       mem,
	output logic                 out_valid,
	output decode_in_t           out_pkt,
	input  logic                 out_accept,
	input  logic                 redirect,
	input  logic [word_bits-1:0] redirect_pc
);
	logic [word_bits-1:0] pc;
	logic                 pending;
	logic                 discard;
	logic                 issue;

	// New request only with an empty (or draining) buffer
	// So a returning word always has a slot
	assign issue = !mem.start && !pending && (!out_valid || out_accept) && !redirect;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc        <= reset_pc;
			mem.start <= 1'b0;
			pending   <= 1'b0;
			discard   <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (out_valid && out_accept)
				out_valid <= 1'b0;
			if (issue) begin
				mem.start <= 1'b1;
				pc        <= pc + 32'd4;
			end
			// Request taken by memory
			if (mem.start && mem.ready) begin
				mem.start <= 1'b0;
				pending   <= 1'b1;
			end
			// Response, dropped if stale
			if (pending && mem.valid) begin
				pending <= 1'b0;
				discard <= 1'b0;
				if (!discard && !redirect)
					out_valid <= 1'b1;
			end
			// Redirect kills the buffer, marks any fetch still out there
			if (redirect) begin
				pc        <= redirect_pc;
				out_valid <= 1'b0;
				if (mem.start || (pending && !mem.valid))
					discard <= 1'b1;
			end
		end
	end

	// Address stays put while start is held
	always_ff @(posedge clk) begin
		if (issue)
			mem.addr <= pc;
		if (pending && mem.valid)
			out_pkt <= '{pc: mem.addr, inst: mem.inst};
	end
endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import core_isa_pkg::*, core_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  decode_in_t           in_pkt,
	output logic                 in_accept,
	output logic [4:0]           rs1_addr,
	output logic [4:0]           rs2_addr,
	input  logic [word_bits-1:0] rs1_data,
	input  logic [word_bits-1:0] rs2_data,
	input  logic                 wb_en,
	input  logic [4:0]           wb_addr,
	output logic                 out_valid,
	output exec_in_t             out_pkt,
	input  logic                 out_accept,
	input  logic                 redirect
);
	logic [31:0]          inst;
	opcode_t              opcode;
	logic [2:0]           funct3;
	logic                 funct7_5;
	logic [4:0]           rd;
	logic [word_bits-1:0] imm_i;
	logic [word_bits-1:0] imm_s;
	logic [word_bits-1:0] imm_b;
	logic [word_bits-1:0] imm_j;
	logic [word_bits-1:0] imm_u;
	logic [word_bits-1:0] operand_b;
	logic [word_bits-1:0] target_imm;
	alu_op_t              alu_op;
	br_cond_t             br_cond;
	wb_sel_t              wb_sel;
	logic                 use_rs1;
	logic                 use_rs2;
	logic                 is_load;
	logic                 is_store;
	logic                 writes_rd;
	logic                 stall;
	logic                 issue;
	// One bit per register with a write still in flight
	logic [31:0]          pending;

	//********************
	// Fields and immediates
	//********************
	assign inst     = in_pkt.inst;
	assign opcode   = opcode_t'(inst[6:0]);
	assign funct3   = inst[14:12];
	assign funct7_5 = inst[30];
	assign rd       = inst[11:7];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];
	assign imm_i    = {{20{inst[31]}}, inst[31:20]};
	assign imm_s    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_u    = {inst[31:12], 12'b0};

	// Control decode, anything unknown falls through as a no-op
	always_comb begin
		alu_op     = alu_add;
		br_cond    = br_none;
		wb_sel     = wb_none;
		operand_b  = imm_i;
		target_imm = imm_b;
		use_rs1    = 1'b0;
		use_rs2    = 1'b0;
		is_load    = 1'b0;
		is_store   = 1'b0;
		case (opcode)
			op_lui: begin
				alu_op    = alu_pass_b;
				operand_b = imm_u;
				wb_sel    = wb_alu;
			end
			op_jal: begin
				br_cond    = br_always;
				target_imm = imm_j;
				wb_sel     = wb_pc4;
			end
			op_branch: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				operand_b = rs2_data;
				case (funct3)
					3'b000:  br_cond = br_eq;
					3'b001:  br_cond = br_ne;
					3'b100:  br_cond = br_lt;
					3'b101:  br_cond = br_ge;
					default: br_cond = br_none;
				endcase
			end
			// Word access only, funct3 not checked
			op_load: begin
				use_rs1 = 1'b1;
				is_load = 1'b1;
				wb_sel  = wb_mem;
			end
			op_store: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				operand_b = imm_s;
				is_store  = 1'b1;
			end
			op_imm, op_reg: begin
				use_rs1 = 1'b1;
				wb_sel  = wb_alu;
				if (opcode == op_reg) begin
					use_rs2   = 1'b1;
					operand_b = rs2_data;
				end
				case (funct3)
					3'b000:  alu_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
					3'b001:  alu_op = alu_sll;
					3'b010:  alu_op = alu_slt;
					3'b100:  alu_op = alu_xor;
					3'b101:  alu_op = funct7_5 ? alu_sra : alu_srl;
					3'b110:  alu_op = alu_or;
					3'b111:  alu_op = alu_and;
					// Unsigned compare not supported
					default: wb_sel = wb_none;
				endcase
			end
			default: ;
		endcase
	end

	//********************
	// Scoreboard interlock
	//********************
	assign writes_rd = (wb_sel != wb_none) && (rd != 5'd0);
	// rd also checked, keeps set and clear of one bit apart
	assign stall     = (use_rs1 && pending[rs1_addr]) || (use_rs2 && pending[rs2_addr])
		|| (writes_rd && pending[rd]);
	assign in_accept = in_valid && !stall && (!out_valid || out_accept);
	assign issue     = in_accept && !redirect;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			pending   <= '0;
		end else begin
			if (out_valid && out_accept)
				out_valid <= 1'b0;
			if (issue)
				out_valid <= 1'b1;
			if (wb_en)
				pending[wb_addr] <= 1'b0;
			if (issue && writes_rd)
				pending[rd] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			out_pkt <= '{
				pc:         in_pkt.pc,
				op_a:       rs1_data,
				op_b:       operand_b,
				store_data: rs2_data,
				br_imm:     target_imm,
				alu_op:     alu_op,
				br_cond:    br_cond,
				wb_sel:     wb_sel,
				rd:         rd,
				is_load:    is_load,
				is_store:   is_store
			};
		end
	end
endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import core_isa_pkg::*, core_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  exec_in_t             in_pkt,
	output logic                 in_accept,
	output logic                 out_valid,
	output mem_in_t              out_pkt,
	input  logic                 out_accept,
	output logic                 redirect,
	output logic [word_bits-1:0] redirect_pc
);
	logic [word_bits-1:0] alu_y;
	logic                 taken;

	// ALU, also forms load/store addresses
	always_comb begin
		case (in_pkt.alu_op)
			alu_sub:    alu_y = in_pkt.op_a - in_pkt.op_b;
			alu_and:    alu_y = in_pkt.op_a & in_pkt.op_b;
			alu_or:     alu_y = in_pkt.op_a | in_pkt.op_b;
			alu_xor:    alu_y = in_pkt.op_a ^ in_pkt.op_b;
			alu_slt:    alu_y = {31'b0, $signed(in_pkt.op_a) < $signed(in_pkt.op_b)};
			alu_sll:    alu_y = in_pkt.op_a << in_pkt.op_b[4:0];
			alu_srl:    alu_y = in_pkt.op_a >> in_pkt.op_b[4:0];
			alu_sra:    alu_y = $signed(in_pkt.op_a) >>> in_pkt.op_b[4:0];
			alu_pass_b: alu_y = in_pkt.op_b;
			default:    alu_y = in_pkt.op_a + in_pkt.op_b;
		endcase
	end

	// Signed compares for BLT and BGE
	always_comb begin
		case (in_pkt.br_cond)
			br_eq:     taken = in_pkt.op_a == in_pkt.op_b;
			br_ne:     taken = in_pkt.op_a != in_pkt.op_b;
			br_lt:     taken = $signed(in_pkt.op_a) < $signed(in_pkt.op_b);
			br_ge:     taken = $signed(in_pkt.op_a) >= $signed(in_pkt.op_b);
			br_always: taken = 1'b1;
			default:   taken = 1'b0;
		endcase
	end

	assign in_accept = !out_valid || out_accept;
	// Fires once, in the cycle the branch moves on
	assign redirect    = in_valid && in_accept && taken;
	assign redirect_pc = in_pkt.pc + in_pkt.br_imm;

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else if (in_accept)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_accept) begin
			out_pkt.alu_result <= alu_y;
			// Link value for JAL
			out_pkt.pc4        <= in_pkt.pc + 32'd4;
			out_pkt.store_data <= in_pkt.store_data;
			out_pkt.rd         <= in_pkt.rd;
			out_pkt.wb_sel     <= in_pkt.wb_sel;
			out_pkt.is_load    <= in_pkt.is_load;
			out_pkt.is_store   <= in_pkt.is_store;
		end
	end
endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import core_isa_pkg::*, core_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  mem_in_t              in_pkt,
	output logic                 in_accept,
	data_port_if.requester       mem,
	output logic                 wb_en,
	output logic [4:0]           wb_addr,
	output logic [word_bits-1:0] wb_data
);
	typedef enum logic [1:0] {st_idle, st_wait_cmd, st_wait_data} mem_state_t;

	mem_state_t state;
	logic       done;

	// Packet leaves in the cycle its work finishes
	always_comb begin
		case (state)
			st_idle:      done = in_valid && !in_pkt.is_load && !in_pkt.is_store;
			st_wait_cmd:  done = mem.cmd_ready && in_pkt.is_store;
			st_wait_data: done = mem.rdata_valid;
			default:      done = 1'b0;
		endcase
	end

	assign in_accept = done;

	//********************
	// Bus sequencing
	//********************
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_idle;
			mem.cmd <= cmd_idle;
		end else begin
			case (state)
				st_idle: begin
					if (in_valid && (in_pkt.is_load || in_pkt.is_store)) begin
						state   <= st_wait_cmd;
						mem.cmd <= in_pkt.is_store ? cmd_write : cmd_read;
					end
				end
				st_wait_cmd: begin
					if (mem.cmd_ready) begin
						mem.cmd <= cmd_idle;
						state   <= in_pkt.is_store ? st_idle : st_wait_data;
					end
				end
				st_wait_data: begin
					if (mem.rdata_valid)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Address and data latched once, stable while waiting for cmd_ready
	always_ff @(posedge clk) begin
		if (state == st_idle && in_valid) begin
			mem.addr  <= in_pkt.alu_result;
			mem.wdata <= in_pkt.store_data;
		end
	end

	// Writeback, x0 never written
	assign wb_en   = done && (in_pkt.wb_sel != wb_none) && (in_pkt.rd != 5'd0);
	assign wb_addr = in_pkt.rd;
	assign wb_data = (in_pkt.wb_sel == wb_mem) ? mem.rdata :
		(in_pkt.wb_sel == wb_pc4) ? in_pkt.pc4 : in_pkt.alu_result;
endmodule

// ==== logic/core_pipeline.sv ====
`timescale 1ns/1ps

module core_pipeline import core_isa_pkg::*, core_bus_pkg::*; #(
	parameter logic [word_bits-1:0] reset_pc = '0,
	parameter logic [word_bits-1:0] sp_init  = 32'd1000
) (
	input  logic                 clk,
	input  logic                 reset,
	output logic                 memory_inst_start,
	input  logic                 memory_inst_ready,
	output logic [word_bits-1:0] memory_i_addr,
	input  logic [word_bits-1:0] memory_inst,
	input  logic                 memory_inst_valid,
	output mem_cmd_t             memory_d_cmd,
	input  logic                 memory_d_cmd_ready,
	output logic [word_bits-1:0] memory_d_addr,
	output logic [word_bits-1:0] memory_wdata,
	input  logic [word_bits-1:0] memory_rdata,
	input  logic                 memory_rdata_valid
);
	inst_port_if inst_port ();
	data_port_if data_port ();

	// Stage handshakes
	logic                 f_valid;
	decode_in_t           f_pkt;
	logic                 f_accept;
	logic                 d_valid;
	exec_in_t             d_pkt;
	logic                 d_accept;
	logic                 e_valid;
	mem_in_t              e_pkt;
	logic                 e_accept;
	logic                 redirect;
	logic [word_bits-1:0] redirect_pc;

	// Register file ports
	logic [4:0]           rs1_addr;
	logic [4:0]           rs2_addr;
	logic [word_bits-1:0] rs1_data;
	logic [word_bits-1:0] rs2_data;
	logic                 wb_en;
	logic [4:0]           wb_addr;
	logic [word_bits-1:0] wb_data;

	//********************
	// Memory port mapping
	//********************
	assign memory_inst_start     = inst_port.start;
	assign memory_i_addr         = inst_port.addr;
	assign inst_port.ready       = memory_inst_ready;
	assign inst_port.inst        = memory_inst;
	assign inst_port.valid       = memory_inst_valid;
	assign memory_d_cmd          = data_port.cmd;
	assign memory_d_addr         = data_port.addr;
	assign memory_wdata          = data_port.wdata;
	assign data_port.cmd_ready   = memory_d_cmd_ready;
	assign data_port.rdata       = memory_rdata;
	assign data_port.rdata_valid = memory_rdata_valid;

	register_file #(.sp_init(sp_init)) register_file_i (
		.clk(clk), .reset(reset),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	// Fetch feeds the chain
	fetch_stage #(.reset_pc(reset_pc)) fetch_stage_i (
		.clk(clk), .reset(reset), .mem(inst_port),
		.out_valid(f_valid), .out_pkt(f_pkt), .out_accept(f_accept),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	decode_stage decode_stage_i (
		.clk(clk), .reset(reset),
		.in_valid(f_valid), .in_pkt(f_pkt), .in_accept(f_accept),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wb_en(wb_en), .wb_addr(wb_addr),
		.out_valid(d_valid), .out_pkt(d_pkt), .out_accept(d_accept),
		.redirect(redirect)
	);

	execute_stage execute_stage_i (
		.clk(clk), .reset(reset),
		.in_valid(d_valid), .in_pkt(d_pkt), .in_accept(d_accept),
		.out_valid(e_valid), .out_pkt(e_pkt), .out_accept(e_accept),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	// Memory stage drains the chain
	memory_stage memory_stage_i (
		.clk(clk), .reset(reset),
		.in_valid(e_valid), .in_pkt(e_pkt), .in_accept(e_accept),
		.mem(data_port),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);
endmodule

// ==== testbench/core_mem_model.sv ====
`timescale 1ns/1ps

module core_mem_model import core_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 inst_start,
	output logic                 inst_ready,
	input  logic [word_bits-1:0] i_addr,
	output logic [word_bits-1:0] inst,
	output logic                 inst_valid,
	input  mem_cmd_t             d_cmd,
	output logic                 d_cmd_ready,
	input  logic [word_bits-1:0] d_addr,
	input  logic [word_bits-1:0] wdata,
	output logic [word_bits-1:0] rdata,
	output logic                 rdata_valid
);
	localparam int unsigned depth = 64;

	// Separate instruction and data arrays, both word indexed
	logic [word_bits-1:0] rom [depth];
	logic [word_bits-1:0] ram [depth];
	integer               seed = 91000;
	logic                 i_busy;
	logic [1:0]           i_wait;
	logic [5:0]           i_index;
	logic                 r_busy;
	logic [1:0]           d_wait;
	logic [5:0]           r_index;

	initial begin
		inst_ready  = 1'b0;
		inst        = '0;
		inst_valid  = 1'b0;
		d_cmd_ready = 1'b0;
		rdata       = '0;
		rdata_valid = 1'b0;
		for (int i = 0; i < depth; i++) begin
			// NOP everywhere until the program is placed
			rom[6'(i)] = 32'h0000_0013;
			// Data word depends on its byte address
			ram[6'(i)] = 32'ha500_0000 ^ (i << 2);
		end
	end

	//********************
	// Both ports, one seed
	//********************
	always @(posedge clk) begin
		if (reset) begin
			inst_ready  <= 1'b0;
			inst_valid  <= 1'b0;
			d_cmd_ready <= 1'b0;
			rdata_valid <= 1'b0;
			i_busy      <= 1'b0;
			i_wait      <= 2'd0;
			r_busy      <= 1'b0;
			d_wait      <= 2'd0;
		end else begin
			// Ready and valid are single-cycle pulses
			inst_ready  <= 1'b0;
			inst_valid  <= 1'b0;
			d_cmd_ready <= 1'b0;
			rdata_valid <= 1'b0;

			// Instruction side
			if (i_busy) begin
				if (i_wait == 2'd0) begin
					inst_valid <= 1'b1;
					inst       <= rom[i_index];
					i_busy     <= 1'b0;
					i_wait     <= 2'($random(seed));
				end else
					i_wait <= i_wait - 2'd1;
			end else if (inst_start && inst_ready) begin
				i_busy  <= 1'b1;
				i_index <= i_addr[7:2];
				i_wait  <= 2'($random(seed));
			end else if (inst_start) begin
				if (i_wait == 2'd0)
					inst_ready <= 1'b1;
				else
					i_wait <= i_wait - 2'd1;
			end

			// Data side, a write lands at the command handshake
			if (r_busy) begin
				if (d_wait == 2'd0) begin
					rdata_valid <= 1'b1;
					rdata       <= ram[r_index];
					r_busy      <= 1'b0;
					d_wait      <= 2'($random(seed));
				end else
					d_wait <= d_wait - 2'd1;
			end else if (d_cmd != cmd_idle && d_cmd_ready) begin
				d_wait <= 2'($random(seed));
				if (d_cmd == cmd_write)
					ram[d_addr[7:2]] <= wdata;
				else begin
					r_busy  <= 1'b1;
					r_index <= d_addr[7:2];
				end
			end else if (d_cmd != cmd_idle) begin
				if (d_wait == 2'd0)
					d_cmd_ready <= 1'b1;
				else
					d_wait <= d_wait - 2'd1;
			end
		end
	end
endmodule

// ==== testbench/core_pipeline_tb.sv ====
`timescale 1ns/1ps

module core_pipeline_tb import core_bus_pkg::*; ();
	localparam logic [word_bits-1:0] reset_pc   = 32'h0;
	localparam logic [word_bits-1:0] sp_init    = 32'd1000;
	localparam int                   clk_period = 40;

	logic                 clk = 1'b0;
	logic                 reset = 1'b1;
	logic                 memory_inst_start;
	logic                 memory_inst_ready;
	logic [word_bits-1:0] memory_i_addr;
	logic [word_bits-1:0] memory_inst;
	logic                 memory_inst_valid;
	mem_cmd_t             memory_d_cmd;
	logic                 memory_d_cmd_ready;
	logic [word_bits-1:0] memory_d_addr;
	logic [word_bits-1:0] memory_wdata;
	logic [word_bits-1:0] memory_rdata;
	logic                 memory_rdata_valid;
	// Expected stores, in program order
	logic [word_bits-1:0] exp_addr [32];
	logic [word_bits-1:0] exp_data [32];
	int                   num_exp = 0;
	int                   store_idx = 0;
	int                   prog_len = 0;
	logic                 fetch_seen = 1'b0;
	logic                 store_fire;

	always #(clk_period / 2) clk = ~clk;

	core_pipeline #(.reset_pc(reset_pc), .sp_init(sp_init)) core_pipeline_i (
		.clk(clk), .reset(reset),
		.memory_inst_start(memory_inst_start), .memory_inst_ready(memory_inst_ready),
		.memory_i_addr(memory_i_addr), .memory_inst(memory_inst),
		.memory_inst_valid(memory_inst_valid),
		.memory_d_cmd(memory_d_cmd), .memory_d_cmd_ready(memory_d_cmd_ready),
		.memory_d_addr(memory_d_addr), .memory_wdata(memory_wdata),
		.memory_rdata(memory_rdata), .memory_rdata_valid(memory_rdata_valid)
	);

	core_mem_model core_mem_model_i (
		.clk(clk), .reset(reset),
		.inst_start(memory_inst_start), .inst_ready(memory_inst_ready),
		.i_addr(memory_i_addr), .inst(memory_inst), .inst_valid(memory_inst_valid),
		.d_cmd(memory_d_cmd), .d_cmd_ready(memory_d_cmd_ready), .d_addr(memory_d_addr),
		.wdata(memory_wdata), .rdata(memory_rdata), .rdata_valid(memory_rdata_valid)
	);

	//********************
	// RV32I encodings
	//********************
	function automatic logic [31:0] imm_op(input int f3, input int rd, input int rs1,
		input int imm);
		return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'b0010011};
	endfunction

	function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] load_word(input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
	endfunction

	function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
		logic [11:0] v;
		v = 12'(imm);
		return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
		input int imm);
		logic [12:0] v;
		v = 13'(imm);
		return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] upper_imm(input int rd, input int imm);
		return {20'(imm), 5'(rd), 7'b0110111};
	endfunction

	function automatic logic [31:0] jump_link(input int rd, input int imm);
		logic [20:0] v;
		v = 21'(imm);
		return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
	endfunction

	task automatic place_inst(input logic [31:0] word);
		core_mem_model_i.rom[6'(prog_len)] = word;
		prog_len++;
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr[5'(num_exp)] = addr;
		exp_data[5'(num_exp)] = data;
		num_exp++;
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// Program and the stores it must produce
	task automatic build_test();
		place_inst(imm_op(0, 10, 0, 128));     // x10 = 0x80, store base
		place_inst(store_word(2, 10, 0));      // x2 untouched since reset
		place_inst(imm_op(0, 1, 0, 5));
		place_inst(imm_op(0, 3, 0, 7));
		place_inst(reg_op(0, 0, 4, 1, 3));    // add
		place_inst(store_word(4, 10, 4));
		place_inst(reg_op(32, 0, 5, 1, 3));   // sub
		place_inst(store_word(5, 10, 8));
		place_inst(reg_op(0, 2, 6, 5, 1));    // slt
		place_inst(store_word(6, 10, 12));
		place_inst(imm_op(5, 7, 5, 'h401));    // srai by 1
		place_inst(store_word(7, 10, 16));
		place_inst(upper_imm(8, 'h12345));
		place_inst(imm_op(6, 8, 8, 'h678));    // ori
		place_inst(reg_op(0, 4, 9, 8, 1));    // xor
		place_inst(store_word(9, 10, 20));
		// Load then use at once
		place_inst(load_word(11, 10, -64));
		place_inst(imm_op(0, 12, 11, 1));
		place_inst(store_word(12, 10, 24));
		place_inst(branch(0, 1, 3, 8));        // beq, falls through
		place_inst(store_word(1, 10, 28));
		place_inst(branch(1, 1, 3, 8));        // bne, taken
		place_inst(store_word(3, 10, 60));     // skipped
		place_inst(jump_link(13, 8));
		place_inst(store_word(3, 10, 60));     // skipped
		place_inst(store_word(13, 10, 32));
		place_inst(imm_op(0, 0, 0, 55));       // x0 stays zero
		place_inst(store_word(0, 10, 36));
		place_inst(branch(4, 5, 1, 8));        // blt, taken
		place_inst(store_word(3, 10, 60));     // skipped
		place_inst(branch(5, 5, 1, 8));        // bge, falls through
		place_inst(reg_op(0, 1, 14, 1, 1));   // sll
		place_inst(reg_op(0, 5, 15, 5, 1));   // srl
		place_inst(imm_op(7, 16, 8, 255));     // andi
		place_inst(store_word(14, 10, 40));
		place_inst(store_word(15, 10, 44));
		place_inst(store_word(16, 10, 48));
		place_inst(jump_link(0, 0));           // spin here

		expect_store(32'h80, sp_init);
		expect_store(32'h84, 32'(5 + 7));
		expect_store(32'h88, 32'(5 - 7));
		expect_store(32'h8c, 32'(-2 < 5));
		expect_store(32'h90, 32'(-2 >>> 1));
		expect_store(32'h94, ((32'h12345 << 12) | 32'h678) ^ 32'd5);
		// Preloaded word at 0x40, plus one
		expect_store(32'h98, (32'ha500_0000 ^ 32'h40) + 32'd1);
		expect_store(32'h9c, 32'd5);
		// Link of the JAL at word 23
		expect_store(32'ha0, reset_pc + 32'(23 * 4 + 4));
		expect_store(32'ha4, 32'd0);
		expect_store(32'ha8, 32'd5 << 5);
		expect_store(32'hac, 32'hffff_fffe >> 5);
		expect_store(32'hb0, 32'h1234_5678 & 32'hff);
	endtask

	assign store_fire = (memory_d_cmd == cmd_write) && memory_d_cmd_ready;

	always @(posedge clk) begin
		if (!reset) begin
			if (memory_inst_start && memory_inst_ready)
				fetch_seen <= 1'b1;
			if (store_fire)
				store_idx <= store_idx + 1;
		end
	end

	//********************
	// Checks
	//********************
	assert property (@(posedge clk) reset |=> (!memory_inst_start && memory_d_cmd == cmd_idle))
		else report_mismatch("ports not idle after reset");

	assert property (@(posedge clk) disable iff (reset)
		(memory_inst_start && memory_inst_ready && !fetch_seen) |-> memory_i_addr == reset_pc)
		else report_mismatch("first fetch address differs from the reset pc");

	// Order, address and data of every store
	assert property (@(posedge clk) disable iff (reset)
		store_fire |-> (store_idx < num_exp && memory_d_addr == exp_addr[5'(store_idx)]
			&& memory_wdata == exp_data[5'(store_idx)]))
		else report_mismatch($sformatf("store %0d wrote %h to address %h",
			$sampled(store_idx), $sampled(memory_wdata), $sampled(memory_d_addr)));

	assert property (@(posedge clk) disable iff (reset)
		(memory_d_cmd != cmd_idle && !memory_d_cmd_ready)
			|=> ($stable(memory_d_cmd) && $stable(memory_d_addr) && $stable(memory_wdata)))
		else report_mismatch("data command changed while waiting for cmd_ready");

	initial begin
		@(posedge clk);
		build_test();
		repeat (9) @(posedge clk);
		reset <= 1'b0;
		wait (store_idx == num_exp);
		// Let the final loop spin, an extra store would fire a check
		repeat (100) @(posedge clk);
		$display("TESTS PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		wait (prog_len > 0);
		#(prog_len * 40 * clk_period);
		$display("Timeout, the expected stores did not all arrive in time");
		$display("TESTS FAILED");
		$fatal(1);
	end
endmodule

// ==== core_pipeline.f ====
logic/core_bus_pkg.sv
logic/core_isa_pkg.sv
logic/core_mem_if.sv
logic/register_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/core_pipeline.sv
testbench/core_mem_model.sv
testbench/core_pipeline_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vcore_pipeline_tb

.PHONY: compile run clean

compile:
	verilator --binary --assert --timescale 1ns/1ps -j 0 \
		--top-module core_pipeline_tb -f core_pipeline.f -Mdir obj_dir

# Pass only if the pass line shows up in the simulation output
run: compile
	./$(SIM) | tee /dev/stderr | grep -x "TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir
